/* rtl/pq_pkg.sv */
/*
  Shared types for the APB replace-top priority queue.
  Holds the APB request and response structs, the register map and the
  opcode enum that the slave decodes each access into. Modules reference
  these by scoped name.
*/

package pq_pkg;

  localparam int APB_ADDR_W = 8;   // APB address bus width
  localparam int APB_DATA_W = 32;  // APB data bus width

  // Master to slave
  typedef struct packed {
    logic                  psel;     // Slave select
    logic                  penable;  // High in the access phase
    logic                  pwrite;   // 1 = write, 0 = read
    logic [APB_ADDR_W-1:0] paddr;    // Byte offset
    logic [APB_DATA_W-1:0] pwdata;   // Write data
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;   // Read data, valid on completion
    logic                  pready;   // Completes the access phase
    logic                  pslverr;  // Error flag, valid on completion
  } apb_rsp_t;

  // Register map
  localparam logic [APB_ADDR_W-1:0] REG_REPLACE = 8'h00;  // WO, replace top
  localparam logic [APB_ADDR_W-1:0] REG_TOP     = 8'h04;  // RO, current max
  localparam logic [APB_ADDR_W-1:0] REG_COUNT   = 8'h08;  // RO, replace count

  // Decoded access kind
  typedef enum logic [2:0] {
    OP_NONE       = 3'd0,  // No slave selected
    OP_REPLACE    = 3'd1,  // Write to REG_REPLACE
    OP_READ_TOP   = 3'd2,  // Read of REG_TOP
    OP_READ_COUNT = 3'd3,  // Read of REG_COUNT
    OP_ERROR      = 3'd4   // Wrong direction or unknown offset
  } pq_op_e;

endpackage

/* rtl/register_array.sv */
/*
  Systolic max priority queue on a register array.
  Every clock runs an even-pair compare-swap followed by an odd-pair
  compare-swap, so large values travel toward slot 0 by up to two places.
  A replace pulse overwrites slot 0 with new_entry, which drops the current
  maximum. Slot 0 is visible as max_entry. All entries reset to zero.
*/

`timescale 1ns/1ps

module register_array #(
  parameter int QUEUE_SIZE = 8,   // Number of entries, 2 or more
  parameter int DATA_WIDTH = 16   // Entry width
) (
  input  logic                  CLK,
  input  logic                  RSTn,
  input  logic                  replace,    // One-cycle pulse, load slot 0
  input  logic [DATA_WIDTH-1:0] new_entry,  // Value written into slot 0
  output logic [DATA_WIDTH-1:0] max_entry   // Slot 0
);

  localparam int PAIR_COUNT = (QUEUE_SIZE + 1) / 2;  // Even pairs, last may be single

  logic [DATA_WIDTH-1:0] entry      [QUEUE_SIZE];  // Queue storage
  logic [DATA_WIDTH-1:0] next_entry [QUEUE_SIZE];  // State after one full step
  logic [DATA_WIDTH-1:0] pair_max   [PAIR_COUNT];  // Winner of even pair i
  logic [DATA_WIDTH-1:0] pair_min   [PAIR_COUNT];  // Loser of even pair i

  // Even phase, pairs (0,1), (2,3), ...
  always_comb begin : even_phase
    for (int i = 0; i < PAIR_COUNT; i++) begin
      if (2 * i + 1 < QUEUE_SIZE) begin
        if (entry[2*i] >= entry[2*i+1]) begin
          pair_max[i] = entry[2*i];
          pair_min[i] = entry[2*i+1];
        end else begin
          pair_max[i] = entry[2*i+1];
          pair_min[i] = entry[2*i];
        end
      end else begin
        pair_max[i] = entry[2*i];  // Odd size, lone tail entry
        pair_min[i] = entry[2*i];
      end
    end
  end

  // Odd phase on the even-phase result, pairs (1,2), (3,4), ...
  always_comb begin : odd_phase
    for (int i = 0; i < QUEUE_SIZE; i++) begin
      next_entry[i] = entry[i];  // Default, every slot overwritten below
    end
    next_entry[0] = pair_max[0];  // Head winner needs no second compare
    for (int i = 1; i < PAIR_COUNT; i++) begin
      // Loser of pair i-1 meets winner of pair i
      if (pair_min[i-1] >= pair_max[i]) begin
        next_entry[2*i-1] = pair_min[i-1];
        next_entry[2*i]   = pair_max[i];
      end else begin
        next_entry[2*i-1] = pair_max[i];
        next_entry[2*i]   = pair_min[i-1];
      end
    end
    if (QUEUE_SIZE % 2 == 0) begin
      next_entry[QUEUE_SIZE-1] = pair_min[PAIR_COUNT-1];  // Tail has no odd partner
    end
  end

  always_ff @(posedge CLK or negedge RSTn) begin
    if (!RSTn) begin
      for (int i = 0; i < QUEUE_SIZE; i++) begin
        entry[i] <= '0;  // Queue starts as all zeros
      end
    end else begin
      for (int i = 0; i < QUEUE_SIZE; i++) begin
        entry[i] <= next_entry[i];
      end
      if (replace) begin
        entry[0] <= new_entry;  // Old top is discarded
      end
    end
  end

  assign max_entry = entry[0];

  // Without a replace the top can only be swapped for something larger
  a_top_monotonic: assert property (
    @(posedge CLK) disable iff (!RSTn)
    !$past(replace) |-> (max_entry >= $past(max_entry))
  ) else $error("register_array: top decreased without a replace");

endmodule

/* rtl/pq_apb_slave.sv */
/*
  APB front end of the replace-top priority queue.
  Decodes each access into an opcode, turns a write of REG_REPLACE into a
  one-cycle replace pulse, and serves reads of the top and of a 16-bit
  replace counter. After a replace, pready is held low for QUEUE_SIZE
  cycles so the array can bring the new maximum back to slot 0.
  Bad direction or unknown offsets complete with pslverr and no side effect.
*/

`timescale 1ns/1ps

module pq_apb_slave #(
  parameter int QUEUE_SIZE = 8,   // Array depth, also the settle length
  parameter int DATA_WIDTH = 16   // Entry width
) (
  input  logic                  CLK,
  input  logic                  RSTn,
  input  pq_pkg::apb_req_t      apb_req,    // APB request from master
  output pq_pkg::apb_rsp_t      apb_rsp,    // APB response to master
  input  logic [DATA_WIDTH-1:0] max_entry,  // Current top of the array
  output logic                  replace,    // Pulse, replace top
  output logic [DATA_WIDTH-1:0] new_entry   // Value for the replace
);

  localparam int SETTLE_W = $clog2(QUEUE_SIZE + 1);  // Holds 0..QUEUE_SIZE
  localparam int COUNT_W  = 16;                      // Replace counter width

  pq_pkg::pq_op_e                op;           // Decoded current access
  logic                          access;       // Access phase of a transfer
  logic                          settled;      // Array has finished sorting
  logic                          done;         // Transfer completes this cycle
  logic [SETTLE_W-1:0]           settle_cnt;   // Cycles left in settle window
  logic [COUNT_W-1:0]            replace_cnt;  // Completed replaces, wraps
  logic [pq_pkg::APB_DATA_W-1:0] rdata;        // Read mux output

  // Address and direction to opcode
  always_comb begin : decode
    op = pq_pkg::OP_NONE;  // Nothing selected
    if (apb_req.psel) begin
      case (apb_req.paddr)
        pq_pkg::REG_REPLACE: begin
          op = apb_req.pwrite ? pq_pkg::OP_REPLACE : pq_pkg::OP_ERROR;  // Write only
        end
        pq_pkg::REG_TOP: begin
          op = apb_req.pwrite ? pq_pkg::OP_ERROR : pq_pkg::OP_READ_TOP;  // Read only
        end
        pq_pkg::REG_COUNT: begin
          op = apb_req.pwrite ? pq_pkg::OP_ERROR : pq_pkg::OP_READ_COUNT;  // Read only
        end
        default: begin
          op = pq_pkg::OP_ERROR;  // Unmapped offset
        end
      endcase
    end
  end

  assign access  = apb_req.psel & apb_req.penable;
  assign settled = (settle_cnt == '0);
  assign done    = access & settled;  // Zero wait states when idle

  // Replace fires in the completing access cycle
  assign replace   = done & (op == pq_pkg::OP_REPLACE);
  assign new_entry = apb_req.pwdata[DATA_WIDTH-1:0];  // Upper bits ignored

  // Settle window, reloaded by every replace
  always_ff @(posedge CLK or negedge RSTn) begin
    if (!RSTn) begin
      settle_cnt <= '0;
    end else if (replace) begin
      settle_cnt <= SETTLE_W'(QUEUE_SIZE);  // One step per slot is enough
    end else if (!settled) begin
      settle_cnt <= settle_cnt - 1'b1;
    end
  end

  // Completed replace counter
  always_ff @(posedge CLK or negedge RSTn) begin
    if (!RSTn) begin
      replace_cnt <= '0;
    end else if (replace) begin
      replace_cnt <= replace_cnt + 1'b1;  // Wraps at 2^16
    end
  end

  // Read data, zero extended
  always_comb begin : read_mux
    rdata = '0;
    case (op)
      pq_pkg::OP_READ_TOP: begin
        rdata[DATA_WIDTH-1:0] = max_entry;
      end
      pq_pkg::OP_READ_COUNT: begin
        rdata[COUNT_W-1:0] = replace_cnt;
      end
      default: begin
        rdata = '0;  // Writes and errors return zero
      end
    endcase
  end

  // Response is only meaningful in the completing cycle
  always_comb begin : response
    apb_rsp         = '0;
    apb_rsp.pready  = done;
    apb_rsp.pslverr = done & (op == pq_pkg::OP_ERROR);
    apb_rsp.prdata  = done ? rdata : '0;
  end

  // Array must be settled before its top is replaced again
  a_replace_when_settled: assert property (
    @(posedge CLK) disable iff (!RSTn)
    replace |-> (settle_cnt == '0)
  ) else $error("pq_apb_slave: replace issued inside settle window");

  // Bus stays stalled for the whole settle window
  a_stall_in_window: assert property (
    @(posedge CLK) disable iff (!RSTn)
    (settle_cnt != '0) |-> !apb_rsp.pready
  ) else $error("pq_apb_slave: pready high while array is settling");

  // Master side, a stalled request must not change under the slave
  a_req_held: assert property (
    @(posedge CLK) disable iff (!RSTn)
    (access && !apb_rsp.pready) |=> $stable(apb_req)
  ) else $error("pq_apb_slave: request changed before completion");

endmodule

/* rtl/apb_priority_queue.sv */
/*
  Top level of the APB replace-top priority queue.
  The APB slave decodes bus accesses and paces replaces; the register
  array holds the entries and keeps the maximum at slot 0.
  QUEUE_SIZE and DATA_WIDTH are set here and passed to both blocks.
*/

`timescale 1ns/1ps

module apb_priority_queue #(
  parameter int QUEUE_SIZE = 8,   // Number of entries, 2 or more
  parameter int DATA_WIDTH = 16   // Entry width, at most APB data width
) (
  input  logic             CLK,
  input  logic             RSTn,
  input  pq_pkg::apb_req_t apb_req,  // APB request
  output pq_pkg::apb_rsp_t apb_rsp   // APB response
);

  logic                  replace;    // Slave to array, replace pulse
  logic [DATA_WIDTH-1:0] new_entry;  // Slave to array, value to insert
  logic [DATA_WIDTH-1:0] max_entry;  // Array to slave, current top

  // Bus front end
  pq_apb_slave #(
    .QUEUE_SIZE (QUEUE_SIZE),
    .DATA_WIDTH (DATA_WIDTH)
  ) slave_i (
    .CLK       (CLK),
    .RSTn      (RSTn),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .max_entry (max_entry),
    .replace   (replace),
    .new_entry (new_entry)
  );

  // Systolic storage
  register_array #(
    .QUEUE_SIZE (QUEUE_SIZE),
    .DATA_WIDTH (DATA_WIDTH)
  ) array_i (
    .CLK       (CLK),
    .RSTn      (RSTn),
    .replace   (replace),
    .new_entry (new_entry),
    .max_entry (max_entry)
  );

endmodule

/* test/pq_ref_model.svh */
/*
  Reference model of the replace-top priority queue, included inside the
  testbench module. Keeps the queue as an unordered multiset of entries
  and derives the expected top, replace count and error flag from the
  register map. Expects QUEUE_SIZE and DATA_WIDTH in the including scope.
*/

`ifndef PQ_REF_MODEL_SVH
`define PQ_REF_MODEL_SVH

logic [DATA_WIDTH-1:0] model_entry [QUEUE_SIZE];  // Multiset, order is irrelevant
int unsigned           model_replaces;            // Completed replaces, unwrapped

// Queue of zeros, no replaces yet
function automatic void model_reset();
  for (int i = 0; i < QUEUE_SIZE; i++) begin
    model_entry[i] = '0;
  end
  model_replaces = 0;
endfunction

// Largest value in the multiset
function automatic logic [DATA_WIDTH-1:0] model_top();
  logic [DATA_WIDTH-1:0] top;
  top = model_entry[0];
  for (int i = 1; i < QUEUE_SIZE; i++) begin
    if (model_entry[i] > top) top = model_entry[i];
  end
  return top;
endfunction

// Drop one copy of the maximum and insert the new value in its place
function automatic void model_replace(input logic [DATA_WIDTH-1:0] value);
  int top_idx;
  top_idx = 0;
  for (int i = 1; i < QUEUE_SIZE; i++) begin
    if (model_entry[i] > model_entry[top_idx]) top_idx = i;
  end
  model_entry[top_idx] = value;
  model_replaces++;
endfunction

// Counter register is 16 bits and wraps
function automatic logic [15:0] model_count();
  return 16'(model_replaces);
endfunction

// Wrong direction or unmapped offset gives an error
function automatic logic model_slverr(input logic write, input logic [7:0] addr);
  case (addr)
    pq_pkg::REG_REPLACE: return !write;  // Write only
    pq_pkg::REG_TOP:     return write;   // Read only
    pq_pkg::REG_COUNT:   return write;   // Read only
    default:             return 1'b1;
  endcase
endfunction

`endif

/* test/tb_apb_priority_queue.sv */
/*
  Testbench for the APB replace-top priority queue.
  Drives replaces and reads over APB, 1 ns after each rising edge, and
  compares every read with the included reference model. Covers reset
  values, random replaces, back-to-back writes under stall, error
  responses, ties and the all-ones value. A watchdog bounds the run.
*/

`timescale 1ns/1ps

module tb_apb_priority_queue;

  localparam int QUEUE_SIZE = 8;
  localparam int DATA_WIDTH = 16;
  localparam int CLK_PERIOD = 100;  // ns
  localparam int N_RANDOM   = 200;  // Replace plus read pairs
  localparam int N_BURST    = 16;   // Replaces with no read between
  localparam int N_TIE      = 12;   // Tie and width-limit replaces
  localparam int NUM_OPS    = 2 * N_RANDOM + N_BURST + 2 * N_TIE + 12;  // Bus transfers
  localparam longint WATCHDOG_CYCLES = NUM_OPS * (QUEUE_SIZE + 4) + 100;

  logic             CLK;
  logic             RSTn;
  pq_pkg::apb_req_t apb_req;
  pq_pkg::apb_rsp_t apb_rsp;

  integer seed;    // $random state
  int     errors;  // Failed checks
  int     checks;  // All checks

  `include "pq_ref_model.svh"

  apb_priority_queue #(
    .QUEUE_SIZE (QUEUE_SIZE),
    .DATA_WIDTH (DATA_WIDTH)
  ) dut_i (
    .CLK     (CLK),
    .RSTn    (RSTn),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Ends a hung run
  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the APB transfers did not finish in the expected time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t ns %s: got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
    end
  endtask

  // One APB transfer, called 1 ns after a rising edge, returns at the same point
  task automatic run_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
    apb_req.psel    = 1'b1;  // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge CLK);
    #1 apb_req.penable = 1'b1;  // Access phase, held until pready
    do begin
      @(negedge CLK);  // Response settled mid-cycle
    end while (!apb_rsp.pready);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge CLK);  // Completing edge
    #1 apb_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic slverr);
    logic [31:0] unused;
    run_transfer(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic slverr);
    run_transfer(1'b0, addr, 32'h0, data, slverr);
  endtask

  task automatic replace_top(input logic [DATA_WIDTH-1:0] value);
    logic slverr;
    apb_write(pq_pkg::REG_REPLACE, 32'(value), slverr);
    check_value(32'(slverr), 32'(model_slverr(1'b1, pq_pkg::REG_REPLACE)),
                "pslverr on replace");
    model_replace(value);
  endtask

  task automatic read_top_and_compare(input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_read(pq_pkg::REG_TOP, rdata, slverr);
    check_value(32'(slverr), 32'h0, {what, ", pslverr on REG_TOP"});
    check_value(rdata, 32'(model_top()), {what, ", REG_TOP"});
  endtask

  task automatic read_count_and_compare(input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_read(pq_pkg::REG_COUNT, rdata, slverr);
    check_value(32'(slverr), 32'h0, {what, ", pslverr on REG_COUNT"});
    check_value(rdata, 32'(model_count()), {what, ", REG_COUNT"});
  endtask

  initial begin : stimulus
    logic [31:0]           rdata;
    logic                  slverr;
    logic [DATA_WIDTH-1:0] value;
    seed    = 43;
    errors  = 0;
    checks  = 0;
    apb_req = '0;
    RSTn    = 1'b0;
    model_reset();
    repeat (8) @(posedge CLK);
    #1 RSTn = 1'b1;
    @(posedge CLK);
    #1;

    read_top_and_compare("after reset");
    read_count_and_compare("after reset");

    // Random replaces, each followed by a read of the top
    for (int i = 0; i < N_RANDOM; i++) begin
      value = DATA_WIDTH'($random(seed));
      replace_top(value);
      read_top_and_compare("random replace");
    end
    read_count_and_compare("after random group");

    // Writes queue up behind the settle stall
    for (int i = 0; i < N_BURST; i++) begin
      value = DATA_WIDTH'($random(seed));
      replace_top(value);
    end
    read_top_and_compare("after burst");
    read_count_and_compare("after burst");

    // Error transfers, no side effects expected
    apb_write(pq_pkg::REG_TOP, 32'hFFFF_FFFF, slverr);
    check_value(32'(slverr), 32'(model_slverr(1'b1, pq_pkg::REG_TOP)), "write to REG_TOP");
    apb_read(pq_pkg::REG_REPLACE, rdata, slverr);
    check_value(32'(slverr), 32'(model_slverr(1'b0, pq_pkg::REG_REPLACE)),
                "read of REG_REPLACE");
    apb_write(8'h0C, 32'h0000_1234, slverr);
    check_value(32'(slverr), 32'(model_slverr(1'b1, 8'h0C)), "write to offset 0x0C");
    apb_read(8'h0C, rdata, slverr);
    check_value(32'(slverr), 32'(model_slverr(1'b0, 8'h0C)), "read of offset 0x0C");
    read_top_and_compare("after error transfers");
    read_count_and_compare("after error transfers");

    // Ties with the current top, all ones, and a random value in turn
    for (int i = 0; i < N_TIE; i++) begin
      case (i % 3)
        0:       value = model_top();
        1:       value = '1;
        default: value = DATA_WIDTH'($random(seed));
      endcase
      replace_top(value);
      read_top_and_compare("tie or width limit");
    end
    read_count_and_compare("after tie group");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+test
rtl/pq_pkg.sv
rtl/register_array.sv
rtl/pq_apb_slave.sv
rtl/apb_priority_queue.sv
test/tb_apb_priority_queue.sv

/* Bender.yml */
package:
  name: apb_priority_queue

sources:
  - rtl/pq_pkg.sv
  - rtl/register_array.sv
  - rtl/pq_apb_slave.sv
  - rtl/apb_priority_queue.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_apb_priority_queue.sv
